// ==== Makefile ====
TOP = rename_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o V$(TOP)

# bound assertion errors must not stop the run before the final report.
run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/arch_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module arch_map #(
  parameter  int num_pr   = rename_pkg::num_pr_default,
  localparam int pr_w     = $clog2(num_pr),
  localparam int arch_w   = rename_pkg::arch_w,
  localparam int num_arch = rename_pkg::num_arch
) (
  input  wire                           clock,
  input  wire                           reset,
  input  wire                           retire_en,
  input  wire  [arch_w-1:0]             retire_arch,
  input  wire  [pr_w-1:0]               retire_pr,
  output logic [num_arch-1:0][pr_w-1:0] arch_state
);

  logic commit;

  assign commit = retire_en && retire_arch != arch_w'(rename_pkg::zero_arch);

  // committed mapping, also the recovery image for the speculative map.
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int unsigned i = 0; i < num_arch; i++) begin
        arch_state[i] <= pr_w'(rename_pkg::reset_map_pr(i));
      end
    end else if (commit) begin
      arch_state[retire_arch] <= retire_pr;
    end
  end

endmodule

`default_nettype wire

// ==== hw/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list #(
  parameter  int num_pr = rename_pkg::num_pr_default,
  parameter  int num_fl = rename_pkg::num_fl_default,
  localparam int pr_w   = $clog2(num_pr),
  localparam int idx_w  = $clog2(num_fl) + 1,
  localparam int arch_w = rename_pkg::arch_w
) (
  input  wire               clock,
  input  wire               reset,
  input  wire               dispatch_en,
  input  wire               rollback_en,
  input  wire               retire_en,
  input  wire  [arch_w-1:0] dest_arch,
  input  wire  [pr_w-1:0]   told_free,
  input  wire  [idx_w-1:0]  rollback_idx,
  output logic [pr_w-1:0]   alloc_pr,
  output logic [idx_w-1:0]  alloc_idx,
  output logic              free_ok
);

  localparam int slot_w = idx_w - 1;

  // the pointers carry one bit above the slot index, so tail - head is the
  // number of registers handed out and not yet freed.
  logic [num_fl-1:0][pr_w-1:0] slots_q;
  logic [idx_w-1:0]            head_q;
  logic [idx_w-1:0]            tail_q;
  logic [idx_w-1:0]            next_head;
  logic [idx_w-1:0]            next_tail;
  logic [idx_w-1:0]            virtual_tail;
  logic                        zero_dest;
  logic                        move_head;
  logic                        empty;

  assign zero_dest    = dest_arch == arch_w'(rename_pkg::zero_arch);
  assign move_head    = retire_en && told_free != pr_w'(rename_pkg::zero_pr);
  assign next_head    = move_head ? head_q + 1'b1 : head_q;
  assign virtual_tail = zero_dest ? tail_q : tail_q + 1'b1;
  assign next_tail    = rollback_en ? rollback_idx :
                        dispatch_en ? virtual_tail : tail_q;
  assign alloc_idx    = next_tail; // stored outside for rollback.

  // no free register is left once the tail runs a full lap ahead of the head.
  assign empty = tail_q - head_q == idx_w'(num_fl);

  always_comb begin
    if (zero_dest) begin
      alloc_pr = pr_w'(rename_pkg::zero_pr);
    end else if (empty && move_head) begin
      alloc_pr = told_free; // the register freed this cycle goes straight out.
    end else begin
      alloc_pr = slots_q[tail_q[slot_w-1:0]];
    end
  end

  assign free_ok = zero_dest || virtual_tail - next_head <= idx_w'(num_fl);

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q <= '0;
      tail_q <= '0;
      for (int unsigned i = 0; i < num_fl; i++) begin
        slots_q[i] <= pr_w'(rename_pkg::reset_fl_pr(i));
      end
    end else begin
      head_q <= next_head;
      tail_q <= next_tail;
      if (move_head) begin
        slots_q[head_q[slot_w-1:0]] <= told_free;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module map_table #(
  parameter  int num_pr   = rename_pkg::num_pr_default,
  localparam int pr_w     = $clog2(num_pr),
  localparam int arch_w   = rename_pkg::arch_w,
  localparam int num_arch = rename_pkg::num_arch
) (
  input  wire                             clock,
  input  wire                             reset,
  input  wire                             dispatch_en,
  input  wire                             rollback_en,
  input  wire  [arch_w-1:0]               dest_arch,
  input  wire  [arch_w-1:0]               src1_arch,
  input  wire  [arch_w-1:0]               src2_arch,
  input  wire  [pr_w-1:0]                 dest_pr,
  input  wire  [num_arch-1:0][pr_w-1:0]   arch_state,
  output logic [pr_w-1:0]                 src1_pr,
  output logic [pr_w-1:0]                 src2_pr,
  output logic [pr_w-1:0]                 told_pr
);

  logic [num_arch-1:0][pr_w-1:0] map_q;
  logic                          write_en;

  // entry 0 is never written, so arch register 0 keeps physical register 0.
  assign write_en = dispatch_en && dest_arch != arch_w'(rename_pkg::zero_arch);

  // reads see the map before this dispatch lands in it.
  assign src1_pr = map_q[src1_arch];
  assign src2_pr = map_q[src2_arch];
  assign told_pr = map_q[dest_arch];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int unsigned i = 0; i < num_arch; i++) begin
        map_q[i] <= pr_w'(rename_pkg::reset_map_pr(i));
      end
    end else if (rollback_en) begin
      map_q <= arch_state; // squash all speculative renames.
    end else if (write_en) begin
      map_q[dest_arch] <= dest_pr;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rename_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// carries the renamed instruction from the lookup stage to the output register.
interface rename_if #(
  parameter int num_pr = rename_pkg::num_pr_default,
  parameter int num_fl = rename_pkg::num_fl_default
);

  logic                      valid;
  logic [$clog2(num_pr)-1:0] dest_pr;
  logic [$clog2(num_pr)-1:0] told_pr;
  logic [$clog2(num_pr)-1:0] src1_pr;
  logic [$clog2(num_pr)-1:0] src2_pr;
  logic [$clog2(num_fl):0]   fl_idx;  // free-list pointer whose top bit counts laps.

  modport producer (
    output valid, dest_pr, told_pr, src1_pr, src2_pr, fl_idx
  );

  modport consumer (
    input valid, dest_pr, told_pr, src1_pr, src2_pr, fl_idx
  );

endinterface

`default_nettype wire

// ==== hw/rename_out_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_out_stage #(
  parameter  int num_pr = rename_pkg::num_pr_default,
  parameter  int num_fl = rename_pkg::num_fl_default,
  localparam int pr_w   = $clog2(num_pr),
  localparam int idx_w  = $clog2(num_fl) + 1
) (
  input  wire              clock,
  input  wire              reset,
  input  wire              rollback_en,
  rename_if.consumer       stage_in,
  output logic             out_valid,
  output logic [pr_w-1:0]  out_dest_pr,
  output logic [pr_w-1:0]  out_told_pr,
  output logic [pr_w-1:0]  out_src1_pr,
  output logic [pr_w-1:0]  out_src2_pr,
  output logic [idx_w-1:0] out_fl_idx
);

  // a dispatch shows here for exactly one cycle.
  always_ff @(posedge clock) begin
    if (reset || rollback_en) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= stage_in.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (stage_in.valid) begin
      out_dest_pr <= stage_in.dest_pr;
      out_told_pr <= stage_in.told_pr;
      out_src1_pr <= stage_in.src1_pr;
      out_src2_pr <= stage_in.src2_pr;
      out_fl_idx  <= stage_in.fl_idx;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rename_pkg.sv ====
`default_nettype none

// shared sizes and reserved numbers of the rename block.
//
// reset mapping rule, used by free_list, map_table and arch_map:
//   arch register i maps to physical register i.
//   free-list entry i holds physical register num_arch + i.
//   the free-list head and tail pointers both start at 0.
package rename_pkg;

  localparam int num_arch       = 32;
  localparam int num_pr_default = 64;
  localparam int num_fl_default = num_pr_default - num_arch;

  localparam int arch_w = $clog2(num_arch);

  // arch register 0 is never renamed and stays on physical register 0.
  localparam int zero_arch = 0;
  localparam int zero_pr   = 0;

  function automatic int unsigned reset_map_pr(input int unsigned arch);
    return arch;
  endfunction

  function automatic int unsigned reset_fl_pr(input int unsigned entry);
    return num_arch + entry; // the first num_arch registers are mapped at reset.
  endfunction

endpackage

`default_nettype wire

// ==== hw/rename_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_unit #(
  parameter  int num_pr   = rename_pkg::num_pr_default,
  parameter  int num_fl   = rename_pkg::num_fl_default,
  localparam int pr_w     = $clog2(num_pr),
  localparam int idx_w    = $clog2(num_fl) + 1,
  localparam int arch_w   = rename_pkg::arch_w,
  localparam int num_arch = rename_pkg::num_arch
) (
  input  wire               clock,
  input  wire               reset,
  input  wire               dispatch_en,
  input  wire  [arch_w-1:0] dest_arch,
  input  wire  [arch_w-1:0] src1_arch,
  input  wire  [arch_w-1:0] src2_arch,
  output logic              free_ok,
  input  wire               retire_en,
  input  wire  [arch_w-1:0] retire_arch,
  input  wire  [pr_w-1:0]   retire_pr,
  input  wire  [pr_w-1:0]   retire_told,
  input  wire               rollback_en,
  input  wire  [idx_w-1:0]  rollback_idx,
  output logic              out_valid,
  output logic [pr_w-1:0]   out_dest_pr,
  output logic [pr_w-1:0]   out_told_pr,
  output logic [pr_w-1:0]   out_src1_pr,
  output logic [pr_w-1:0]   out_src2_pr,
  output logic [idx_w-1:0]  out_fl_idx
);

  rename_if #(.num_pr(num_pr), .num_fl(num_fl)) lookup ();

  logic [num_arch-1:0][pr_w-1:0] arch_state;

  assign lookup.valid = dispatch_en && !rollback_en; // rollback wins over dispatch.

  free_list #(.num_pr(num_pr), .num_fl(num_fl)) u_free_list (
    .clock, .reset, .dispatch_en, .rollback_en, .retire_en, .dest_arch,
    .told_free (retire_told),
    .rollback_idx,
    .alloc_pr  (lookup.dest_pr),
    .alloc_idx (lookup.fl_idx),
    .free_ok
  );

  map_table #(.num_pr(num_pr)) u_map_table (
    .clock, .reset, .dispatch_en, .rollback_en, .dest_arch, .src1_arch, .src2_arch,
    .dest_pr (lookup.dest_pr),
    .arch_state,
    .src1_pr (lookup.src1_pr),
    .src2_pr (lookup.src2_pr),
    .told_pr (lookup.told_pr)
  );

  arch_map #(.num_pr(num_pr)) u_arch_map (
    .clock, .reset, .retire_en, .retire_arch, .retire_pr, .arch_state
  );

  rename_out_stage #(.num_pr(num_pr), .num_fl(num_fl)) u_out_stage (
    .clock, .reset, .rollback_en,
    .stage_in (lookup.consumer),
    .out_valid, .out_dest_pr, .out_told_pr, .out_src1_pr, .out_src2_pr, .out_fl_idx
  );

endmodule

`default_nettype wire

// ==== tests/rename_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_assert #(
  parameter int num_pr = rename_pkg::num_pr_default
) (
  input wire                          clock,
  input wire                          reset,
  input wire                          dispatch_en,
  input wire                          rollback_en,
  input wire [rename_pkg::arch_w-1:0] dest_arch,
  input wire                          free_ok,
  input wire                          out_valid,
  input wire [$clog2(num_pr)-1:0]     out_dest_pr
);

  int failures = 0; // number of failed properties so far.

  idle_after_reset: assert property (@(posedge clock) reset |=> !out_valid)
    else begin
      failures++;
      $error("out_valid is high after reset");
    end

  no_dispatch_when_full: assert property (
    @(posedge clock) disable iff (reset) dispatch_en |-> free_ok)
    else begin
      failures++;
      $error("dispatch while the free list is empty");
    end

  // a renamed destination never lands on the hard-wired zero register.
  nonzero_dest_pr: assert property (
    @(posedge clock) disable iff (reset)
    (dispatch_en && !rollback_en && dest_arch != '0) |=> out_dest_pr != '0)
    else begin
      failures++;
      $error("non-zero destination got physical register 0");
    end

  idle_after_rollback: assert property (
    @(posedge clock) disable iff (reset) rollback_en |=> !out_valid)
    else begin
      failures++;
      $error("out_valid is high after a rollback");
    end

endmodule

bind rename_unit rename_assert #(.num_pr(num_pr)) protocol_checks (
  .clock(clock), .reset(reset), .dispatch_en(dispatch_en), .rollback_en(rollback_en),
  .dest_arch(dest_arch), .free_ok(free_ok), .out_valid(out_valid), .out_dest_pr(out_dest_pr)
);

`default_nettype wire

// ==== tests/rename_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_tb;

  localparam int pr_w   = $clog2(rename_pkg::num_pr_default);
  localparam int idx_w  = $clog2(rename_pkg::num_fl_default) + 1;
  localparam int arch_w = rename_pkg::arch_w;
  localparam int chk_w  = pr_w > idx_w ? pr_w : idx_w;
  localparam int timeout_cycles = 2000;

  logic              clock;
  logic              reset;
  logic              dispatch_en;
  logic [arch_w-1:0] dest_arch, src1_arch, src2_arch;
  logic              free_ok;
  logic              retire_en;
  logic [arch_w-1:0] retire_arch;
  logic [pr_w-1:0]   retire_pr, retire_told;
  logic              rollback_en;
  logic [idx_w-1:0]  rollback_idx;
  logic              out_valid;
  logic [pr_w-1:0]   out_dest_pr, out_told_pr, out_src1_pr, out_src2_pr;
  logic [idx_w-1:0]  out_fl_idx;

  // the reference model keeps free registers in allocation order, both maps and the ROB.
  logic [pr_w-1:0]   spec_map [rename_pkg::num_arch];
  logic [pr_w-1:0]   commit_map [rename_pkg::num_arch];
  logic [pr_w-1:0]   free_q [$];
  logic [pr_w-1:0]   alloc_log [$];
  logic [idx_w-1:0]  tail_idx;
  logic [arch_w-1:0] rob_arch [$];
  logic [pr_w-1:0]   rob_pr [$];
  logic [pr_w-1:0]   rob_told [$];

  logic              exp_valid;
  logic [pr_w-1:0]   exp_dest, exp_told, exp_src1, exp_src2;
  logic [idx_w-1:0]  exp_idx;
  string             test_name;
  int                errors, checks, cycle_count;

  rename_unit UUT (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [arch_w-1:0] random_arch(input int unsigned low);
    return arch_w'($urandom_range(31, low));
  endfunction

  task automatic check_value(input string what, input logic [chk_w-1:0] expected,
                             input logic [chk_w-1:0] actual);
    checks++;
    assert (expected == actual) else begin
      errors++;
      $display("Mismatch %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic run_cycle(input logic disp, input logic [arch_w-1:0] dest,
                           input logic [arch_w-1:0] src1, input logic [arch_w-1:0] src2,
                           input logic retire, input logic rollback,
                           input logic [idx_w-1:0] rb_idx);
    logic             go;
    logic             ret;
    logic [pr_w-1:0]  told_free;
    logic [idx_w-1:0] squashed;
    int               frees;
    ret       = retire && rob_pr.size() > 0;
    told_free = ret ? rob_told[0] : '0;
    frees     = (told_free != '0) ? 1 : 0;
    go        = disp && (dest == '0 || free_q.size() + frees > 0);
    @(posedge clock);
    dispatch_en  <= go;
    dest_arch    <= dest;
    src1_arch    <= src1;
    src2_arch    <= src2;
    retire_en    <= ret;
    retire_arch  <= ret ? rob_arch[0] : '0;
    retire_pr    <= ret ? rob_pr[0] : '0;
    retire_told  <= told_free;
    rollback_en  <= rollback;
    rollback_idx <= rb_idx;
    @(negedge clock);
    check_value("out_valid", chk_w'(exp_valid), chk_w'(out_valid));
    if (exp_valid) begin
      check_value("dest_pr", chk_w'(exp_dest), chk_w'(out_dest_pr));
      check_value("told_pr", chk_w'(exp_told), chk_w'(out_told_pr));
      check_value("src1_pr", chk_w'(exp_src1), chk_w'(out_src1_pr));
      check_value("src2_pr", chk_w'(exp_src2), chk_w'(out_src2_pr));
      check_value("fl_idx", chk_w'(exp_idx), chk_w'(out_fl_idx));
    end
    check_value("free_ok", chk_w'(dest == '0 || free_q.size() + frees > 0), chk_w'(free_ok));
    exp_valid = go && !rollback;
    exp_told  = spec_map[dest]; // lookups see the map from before this cycle.
    exp_src1  = spec_map[src1];
    exp_src2  = spec_map[src2];
    if (rollback) spec_map = commit_map;
    if (ret) begin
      if (frees != 0) free_q.push_back(told_free);
      if (rob_arch[0] != '0) commit_map[rob_arch[0]] = rob_pr[0];
      void'(rob_arch.pop_front());
      void'(rob_pr.pop_front());
      void'(rob_told.pop_front());
    end
    if (rollback) begin
      squashed = tail_idx - rb_idx;
      repeat (squashed) free_q.push_front(alloc_log.pop_back());
      tail_idx = rb_idx;
      rob_arch.delete();
      rob_pr.delete();
      rob_told.delete();
    end
    if (exp_valid) begin
      exp_dest = '0;
      if (dest != '0) begin
        exp_dest = free_q.pop_front();
        spec_map[dest] = exp_dest;
        alloc_log.push_back(exp_dest);
        tail_idx = tail_idx + 1'b1;
      end
      exp_idx = tail_idx;
      rob_arch.push_back(dest);
      rob_pr.push_back(exp_dest);
      rob_told.push_back(exp_told);
    end
  endtask

  task automatic dispatch_op(input logic [arch_w-1:0] dest, input logic [arch_w-1:0] src1,
                             input logic [arch_w-1:0] src2);
    run_cycle(1'b1, dest, src1, src2, 1'b0, 1'b0, '0);
  endtask

  task automatic retire_op();
    run_cycle(1'b0, 5'd1, 5'd0, 5'd0, 1'b1, 1'b0, '0);
  endtask

  task automatic finish_run();
    int assert_fails;
    assert_fails = UUT.protocol_checks.failures;
    $display("errors: %0d, assertion failures: %0d, checks: %0d", errors, assert_fails, checks);
    if (errors == 0 && assert_fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clock);
      cycle_count++;
    end
    errors++;
    $display("simulation timed out");
    finish_run();
  end

  initial begin
    logic [idx_w-1:0] saved_idx;
    void'($urandom(32'hed50_7fec));
    {dispatch_en, retire_en, rollback_en} = '0;
    {dest_arch, src1_arch, src2_arch, retire_arch} = '0;
    {retire_pr, retire_told, rollback_idx} = '0;
    reset = 1'b1;
    for (int i = 0; i < rename_pkg::num_arch; i++) begin
      spec_map[i]   = pr_w'(i);
      commit_map[i] = pr_w'(i);
    end
    for (int i = 0; i < rename_pkg::num_fl_default; i++) begin
      free_q.push_back(pr_w'(rename_pkg::num_arch + i));
    end
    tail_idx  = '0;
    exp_valid = 1'b0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    test_name = "alloc_order";
    for (int i = 1; i <= 6; i++) dispatch_op(arch_w'(i), random_arch(0), random_arch(0));
    test_name = "zero_dest";
    dispatch_op(5'd0, 5'd2, 5'd0);
    dispatch_op(5'd7, 5'd0, 5'd1);
    test_name = "self_source";
    dispatch_op(5'd3, 5'd3, 5'd1);
    dispatch_op(5'd9, 5'd9, 5'd9);
    dispatch_op(5'd1, 5'd3, 5'd1);
    test_name = "drain_refill";
    while (rob_pr.size() > 0) retire_op();
    while (free_q.size() > 0) dispatch_op(random_arch(1), random_arch(0), random_arch(0));
    run_cycle(1'b0, 5'd4, 5'd4, 5'd0, 1'b0, 1'b0, '0); // free_ok is low with nothing left.
    run_cycle(1'b1, 5'd4, 5'd4, 5'd2, 1'b1, 1'b0, '0); // freed told goes straight out.
    repeat (4) retire_op();
    repeat (4) dispatch_op(random_arch(1), random_arch(0), random_arch(0));
    test_name = "rollback";
    while (rob_pr.size() > 0) retire_op(); // refills the free list first.
    dispatch_op(5'd5, 5'd5, 5'd9);
    saved_idx = exp_idx;
    dispatch_op(5'd6, 5'd5, 5'd0);
    dispatch_op(5'd7, 5'd6, 5'd5);
    dispatch_op(5'd5, 5'd7, 5'd6);
    retire_op(); // only the first of the four commits.
    run_cycle(1'b1, 5'd8, 5'd6, 5'd7, 1'b0, 1'b1, saved_idx); // the dispatch is dropped.
    dispatch_op(5'd6, 5'd5, 5'd7);
    dispatch_op(5'd7, 5'd6, 5'd8);
    test_name = "random_mix";
    repeat (400) begin
      run_cycle($urandom_range(3, 0) != 0, random_arch(0), random_arch(0), random_arch(0),
                $urandom_range(1, 0) == 1, 1'b0, '0);
    end
    run_cycle(1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, '0);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/rename_pkg.sv
hw/rename_if.sv
hw/free_list.sv
hw/map_table.sv
hw/arch_map.sv
hw/rename_out_stage.sv
hw/rename_unit.sv
tests/rename_assert.sv
tests/rename_tb.sv
